// File: hw/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

    ////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////
    localparam int index_width       = 4;   // 16 sets
    localparam int word_offset_width = 2;   // 4 words per line
    localparam int byte_offset_width = word_offset_width + 2;
    localparam int tag_width         = 32 - index_width - byte_offset_width;
    localparam int set_num           = 1 << index_width;
    localparam int word_num          = 1 << word_offset_width;
    localparam int line_bits         = word_num * 32;
    localparam int line_bytes        = line_bits / 8;   // byte enables per line

    ////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////
    typedef logic [31:0]                  word_t;
    typedef logic [31:0]                  addr_t;   // byte address
    typedef logic [tag_width-1:0]         tag_t;
    typedef logic [index_width-1:0]       index_t;
    typedef logic [word_offset_width-1:0] word_sel_t;
    typedef logic [line_bits-1:0]         line_t;
    typedef logic [3:0]                   strb_t;   // one bit per byte lane

    // address fields: | tag | index | word | byte |
    function automatic tag_t get_tag(addr_t addr);
        return addr[31 -: tag_width];
    endfunction

    function automatic index_t get_index(addr_t addr);
        return addr[byte_offset_width +: index_width];
    endfunction

    function automatic word_sel_t get_word(addr_t addr);
        return addr[2 +: word_offset_width];
    endfunction

endpackage

// File: hw/dcache_bus_pkg.sv
package dcache_bus_pkg;
    import dcache_cfg_pkg::*;

    ////////////////////////////////////////
    // processor and memory transfers
    ////////////////////////////////////////
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;   // all zero for a load
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  rlast;
    } mem_rd_beat_t;

    typedef struct packed {
        addr_t waddr;   // line address of the burst
        word_t wdata;
        logic  wlast;
    } mem_wr_beat_t;

    ////////////////////////////////////////
    // state machines
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        idle, lookup, miss, refill, wait_done
    } ctrl_state_t;

    typedef enum logic [1:0] {
        wb_idle, wb_write, wb_done
    } wb_state_t;

endpackage

// File: hw/dcache_arrays.sv
`timescale 1ns/1ps

module dcache_arrays
    import dcache_cfg_pkg::*;
(
    input  logic                         clk,
    input  logic                         rstn,
    input  index_t                       rd_index,
    input  index_t                       wr_index,
    input  logic [1:0]                   tag_we,
    input  tag_t                         wr_tag,
    input  logic [1:0][line_bytes-1:0]   data_we,
    input  line_t                        wr_line,
    input  logic                         touch_way,
    input  logic                         touch_en,
    input  logic                         dirty_set_en,
    input  logic                         dirty_val,
    output tag_t [1:0]                   rd_tag,
    output logic [1:0]                   rd_valid,
    output line_t [1:0]                  rd_line,
    output logic                         victim_way,
    output logic                         victim_dirty
);

    tag_t                     tag_mem  [2][set_num];
    line_t                    data_mem [2][set_num];
    logic [1:0][set_num-1:0]  valid_q;
    logic [1:0][set_num-1:0]  dirty_q;
    logic [set_num-1:0]       lru_q;    // least recently used way per set

    ////////////////////////////////////////
    // tag and data storage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            // byte-writable line
            for (int b = 0; b < line_bytes; b++) begin
                if (data_we[w][b]) begin
                    data_mem[w][wr_index][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
            rd_tag[w]  <= tag_mem[w][rd_index];    // registered read
            rd_line[w] <= data_mem[w][rd_index];
        end
    end

    ////////////////////////////////////////
    // valid, dirty and lru bits
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            lru_q    <= '0;
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (tag_we[w]) begin
                    valid_q[w][wr_index] <= 1'b1;
                end
                rd_valid[w] <= valid_q[w][rd_index];
            end
            if (dirty_set_en) begin
                dirty_q[touch_way][wr_index] <= dirty_val;
            end
            if (touch_en) begin
                lru_q[wr_index] <= ~touch_way;   // other way becomes the older one
            end
        end
    end

    // replacement candidate of the request's set
    assign victim_way   = lru_q[wr_index];
    assign victim_dirty = dirty_q[victim_way][wr_index];

endmodule

// File: hw/refill_unit.sv
`timescale 1ns/1ps

module refill_unit
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  logic         start,
    input  logic         clear,
    input  cpu_req_t     req,
    output logic         d_rvalid,
    input  logic         d_rready,
    output addr_t        d_raddr,
    input  mem_rd_beat_t rd_beat,
    output line_t        fill_line,
    output logic         fill_done
);

    line_t ret_buf;
    line_t st_data;
    line_t st_mask;
    logic  beat;

    assign beat = d_rvalid && d_rready;

    // burst control, d_rvalid stays up until the rlast beat
    always_ff @(posedge clk) begin
        if (!rstn) begin
            d_rvalid  <= 1'b0;
            fill_done <= 1'b0;
        end else if (start) begin
            d_rvalid  <= 1'b1;
            fill_done <= 1'b0;
        end else if (beat && rd_beat.rlast) begin
            d_rvalid  <= 1'b0;
            fill_done <= 1'b1;
        end else if (clear) begin
            fill_done <= 1'b0;
        end
    end

    // return buffer, lowest word arrives first and ends at the bottom
    always_ff @(posedge clk) begin
        if (beat) begin
            ret_buf <= {rd_beat.rdata, ret_buf[line_bits-1:32]};
        end
    end

    assign d_raddr = {req.addr[31:byte_offset_width], {byte_offset_width{1'b0}}};

    ////////////////////////////////////////
    // store merge
    ////////////////////////////////////////
    assign st_data = line_t'(req.wdata) << {get_word(req.addr), 5'b0};
    assign st_mask = line_t'({{8{req.wstrb[3]}}, {8{req.wstrb[2]}},
                              {8{req.wstrb[1]}}, {8{req.wstrb[0]}}})
                     << {get_word(req.addr), 5'b0};

    assign fill_line = (ret_buf & ~st_mask) | (st_data & st_mask);   // a load has no mask

endmodule

// File: hw/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  logic         start,
    input  logic         clear,
    input  logic         victim_dirty,
    input  line_t        victim_line,
    input  tag_t         victim_tag,
    input  index_t       victim_index,
    output logic         d_wvalid,
    input  logic         d_wready,
    output mem_wr_beat_t wr_beat,
    input  logic         d_bvalid,
    output logic         d_bready,
    output logic         wb_done
);

    wb_state_t state;
    line_t     line_q;
    addr_t     addr_q;
    word_sel_t cnt;     // beat counter
    logic      sent;    // all data beats accepted, waiting on the response
    logic      beat;

    assign beat = d_wvalid && d_wready;

    ////////////////////////////////////////
    // write-back FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= wb_idle;
            cnt   <= '0;
            sent  <= 1'b0;
        end else begin
            case (state)
                wb_idle: begin
                    cnt  <= '0;
                    sent <= 1'b0;
                    if (start) begin
                        // a clean victim needs no burst
                        state <= victim_dirty ? wb_write : dcache_bus_pkg::wb_done;
                    end
                end
                wb_write: begin
                    if (beat) begin
                        cnt  <= cnt + 1'b1;
                        sent <= wr_beat.wlast;
                    end
                    if (d_bvalid && d_bready) begin
                        state <= dcache_bus_pkg::wb_done;
                    end
                end
                dcache_bus_pkg::wb_done: begin
                    state <= clear ? wb_idle : dcache_bus_pkg::wb_done;
                end
                default: state <= wb_idle;
            endcase
        end
    end

    // victim capture, then one word out per accepted beat
    always_ff @(posedge clk) begin
        if (state == wb_idle && start) begin
            line_q <= victim_line;
            addr_q <= {victim_tag, victim_index, {byte_offset_width{1'b0}}};
        end else if (beat) begin
            line_q <= line_q >> 32;
        end
    end

    assign d_wvalid      = (state == wb_write) && !sent;
    assign d_bready      = (state == wb_write);
    assign wr_beat.waddr = addr_q;
    assign wr_beat.wdata = line_q[31:0];
    assign wr_beat.wlast = d_wvalid && (cnt == word_sel_t'(word_num - 1));
    assign wb_done       = (state == dcache_bus_pkg::wb_done);

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
    input  logic                         clk,
    input  logic                         rstn,
    // processor side
    input  logic                         rvalid,
    input  logic                         wvalid,
    input  cpu_req_t                     cpu_req,
    output logic                         rready,
    output logic                         wready,
    output word_t                        rdata,
    // arrays
    output index_t                       rd_index,
    output index_t                       wr_index,
    output logic [1:0]                   tag_we,
    output tag_t                         wr_tag,
    output logic [1:0][line_bytes-1:0]   data_we,
    output line_t                        wr_line,
    output logic                         touch_way,
    output logic                         touch_en,
    output logic                         dirty_set_en,
    output logic                         dirty_val,
    input  tag_t [1:0]                   rd_tag,
    input  logic [1:0]                   rd_valid,
    input  line_t [1:0]                  rd_line,
    input  logic                         victim_way,
    // refill and write-back units
    input  line_t                        fill_line,
    input  logic                         fill_done,
    input  logic                         wb_done,
    output logic                         unit_start,
    output logic                         unit_clear,
    output cpu_req_t                     req_q
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic [1:0]  hit;
    logic        cache_hit;
    logic        hit_way;
    logic        is_store;
    logic        done;
    word_sel_t   word_sel;
    line_t       src_line;

    // request buffer, loaded when a request shows up in idle
    always_ff @(posedge clk) begin
        if (state == idle && (rvalid || wvalid)) begin
            req_q <= cpu_req;
        end
    end

    ////////////////////////////////////////
    // main FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            idle:      state_nxt = (rvalid || wvalid) ? lookup : idle;
            lookup:    state_nxt = cache_hit ? idle : miss;
            miss:      state_nxt = fill_done ? refill : miss;   // last beat is in
            refill:    state_nxt = wait_done;
            wait_done: state_nxt = wb_done ? idle : wait_done;
            default:   state_nxt = idle;
        endcase
    end

    // hit check against both ways
    assign is_store  = |req_q.wstrb;
    assign word_sel  = get_word(req_q.addr);
    assign hit[0]    = rd_valid[0] && (rd_tag[0] == get_tag(req_q.addr));
    assign hit[1]    = rd_valid[1] && (rd_tag[1] == get_tag(req_q.addr));
    assign cache_hit = |hit;
    assign hit_way   = hit[1];

    // answer: hit in lookup, or miss once both units are through
    assign done       = (state == lookup && cache_hit) || (state == wait_done && wb_done);
    assign rready     = done && !is_store;
    assign wready     = done && is_store;
    assign unit_start = (state == lookup) && !cache_hit;
    assign unit_clear = (state == wait_done) && wb_done;

    assign src_line = (state == wait_done) ? fill_line : rd_line[hit_way];
    assign rdata    = src_line[word_sel*32 +: 32];

    ////////////////////////////////////////
    // array write control
    ////////////////////////////////////////
    assign rd_index  = get_index(cpu_req.addr);   // read launched from the incoming request
    assign wr_index  = get_index(req_q.addr);
    assign wr_tag    = get_tag(req_q.addr);
    assign dirty_val = is_store;

    always_comb begin
        tag_we       = '0;
        data_we      = '0;
        wr_line      = {word_num{req_q.wdata}};
        touch_en     = 1'b0;
        touch_way    = hit_way;
        dirty_set_en = 1'b0;
        case (state)
            lookup: begin
                if (cache_hit) begin
                    data_we[hit_way] = line_bytes'(req_q.wstrb) << {word_sel, 2'b00};
                    touch_en         = 1'b1;
                    dirty_set_en     = is_store;
                end
            end
            refill: begin
                tag_we[victim_way]  = 1'b1;
                data_we[victim_way] = '1;
                wr_line             = fill_line;   // store already merged in
                touch_en            = 1'b1;
                touch_way           = victim_way;
                dirty_set_en        = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    // processor port
    input  logic         rvalid,
    input  logic         wvalid,
    input  cpu_req_t     cpu_req,
    output logic         rready,
    output logic         wready,
    output word_t        rdata,
    // memory read
    output logic         d_rvalid,
    input  logic         d_rready,
    output addr_t        d_raddr,
    input  mem_rd_beat_t rd_beat,
    // memory write
    output logic         d_wvalid,
    input  logic         d_wready,
    output mem_wr_beat_t wr_beat,
    input  logic         d_bvalid,
    output logic         d_bready
);

    index_t                     rd_index, wr_index;
    logic [1:0]                 tag_we;
    tag_t                       wr_tag;
    logic [1:0][line_bytes-1:0] data_we;
    line_t                      wr_line;
    logic                       touch_way, touch_en, dirty_set_en, dirty_val;
    tag_t [1:0]                 rd_tag;
    logic [1:0]                 rd_valid;
    line_t [1:0]                rd_line;
    logic                       victim_way, victim_dirty;
    line_t                      fill_line;
    logic                       fill_done, wb_done, unit_start, unit_clear;
    cpu_req_t                   req_q;

    dcache_ctrl u_ctrl (
        .clk, .rstn, .rvalid, .wvalid, .cpu_req, .rready, .wready, .rdata,
        .rd_index, .wr_index, .tag_we, .wr_tag, .data_we, .wr_line,
        .touch_way, .touch_en, .dirty_set_en, .dirty_val,
        .rd_tag, .rd_valid, .rd_line, .victim_way,
        .fill_line, .fill_done, .wb_done, .unit_start, .unit_clear, .req_q
    );

    dcache_arrays u_arrays (
        .clk, .rstn, .rd_index, .wr_index, .tag_we, .wr_tag, .data_we, .wr_line,
        .touch_way, .touch_en, .dirty_set_en, .dirty_val,
        .rd_tag, .rd_valid, .rd_line, .victim_way, .victim_dirty
    );

    refill_unit u_refill (
        .clk, .rstn, .start(unit_start), .clear(unit_clear), .req(req_q),
        .d_rvalid, .d_rready, .d_raddr, .rd_beat, .fill_line, .fill_done
    );

    // victim way picked straight off the array read
    writeback_unit u_wb (
        .clk, .rstn, .start(unit_start), .clear(unit_clear), .victim_dirty,
        .victim_line(rd_line[victim_way]), .victim_tag(rd_tag[victim_way]),
        .victim_index(wr_index), .d_wvalid, .d_wready, .wr_beat,
        .d_bvalid, .d_bready, .wb_done
    );

endmodule

// File: verification/dcache_tests.svh
// store bytes laid over the older word
function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
    word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
endfunction

// one request, cycles counts falling edges from valid up to ready
task automatic cpu_access(input addr_t addr, input word_t wdata, input strb_t wstrb,
                          output word_t data, output int cycles);
    logic was_rd;
    @(negedge clk);     // valid stays low for a cycle between requests
    cpu_req = '{addr: addr, wdata: wdata, wstrb: wstrb};
    rvalid  = (wstrb == '0);
    wvalid  = (wstrb != '0);
    cycles  = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > 200) timeout_abort("no ready from the cache within 200 cycles");
    end while (!rready && !wready);
    data   = rdata;
    was_rd = rready;
    @(negedge clk);
    rvalid = 1'b0;
    wvalid = 1'b0;
    check_value("ready kind", 32'(was_rd), 32'(wstrb == '0));
endtask

task automatic mark_bursts();
    rd_mark = rd_bursts;
    wr_mark = wr_bursts;
endtask

task automatic check_bursts(input string what, input int rd_n, input int wr_n);
    check_value({what, " read bursts"}, rd_bursts - rd_mark, rd_n);
    check_value({what, " write bursts"}, wr_bursts - wr_mark, wr_n);
endtask

// load an untouched memory word, a negative exp_cycles skips the latency check
task automatic load_fresh(input addr_t addr, input int exp_cycles);
    word_t d;
    int    cyc;
    cpu_access(addr, '0, '0, d, cyc);
    check_value($sformatf("load %h", addr), d, init_word(addr));
    if (exp_cycles >= 0) check_value($sformatf("latency %h", addr), cyc, exp_cycles);
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////
task automatic load_miss_then_hit();
    mark_bursts();
    load_fresh(32'h0000_0124, -1);
    check_bursts("load miss", 1, 0);
    load_fresh(32'h0000_0124, 1);       // hit answers one cycle after valid
    check_bursts("load hit", 1, 0);
endtask

task automatic store_hit_partial();
    word_t d;
    int    cyc;
    mark_bursts();
    cpu_access(32'h0000_0124, 32'hdead_beef, 4'b0110, d, cyc);
    check_value("store hit latency", cyc, 1);
    cpu_access(32'h0000_0124, '0, '0, d, cyc);
    check_value("load after store hit", d,
                merge_bytes(init_word(32'h0000_0124), 32'hdead_beef, 4'b0110));
    check_bursts("store hit", 0, 0);
endtask

// set 3, word 2
task automatic store_miss_allocate();
    word_t d;
    int    cyc;
    mark_bursts();
    cpu_access(32'h0000_0338, 32'h1234_5678, 4'b1001, d, cyc);
    check_bursts("store miss", 1, 0);
    check_value("refill beats", rd_words.size(), 4);
    check_value("refill memory word", rd_words[2], init_word(32'h0000_0338));
    cpu_access(32'h0000_0338, '0, '0, d, cyc);
    check_value("load after store miss", d,
                merge_bytes(init_word(32'h0000_0338), 32'h1234_5678, 4'b1001));
    load_fresh(32'h0000_0330, 1);       // rest of the line came from memory
endtask

task automatic dirty_eviction();
    addr_t line;
    word_t exp;
    line = 32'h0000_0330;
    exp  = merge_bytes(init_word(line + 8), 32'h1234_5678, 4'b1001);
    load_fresh(32'h0000_0434, -1);      // fills the free way of set 3
    wr_addr_log.delete();
    wr_data_log.delete();
    wr_last_log.delete();
    mark_bursts();
    load_fresh(32'h0000_0530, -1);      // dirty line is now the oldest
    check_bursts("dirty eviction", 1, 1);
    check_value("write beats", wr_data_log.size(), 4);
    for (int k = 0; k < 4; k++) begin
        check_value("write address", wr_addr_log[k], line);
        check_value("write data", wr_data_log[k], (k == 2) ? exp : init_word(line + 4 * k));
        check_value("wlast", 32'(wr_last_log[k]), 32'(k == 3));
    end
    check_value("memory after write-back", mem[mem_index(line + 8)], exp);
endtask

task automatic clean_eviction();
    load_fresh(32'h0000_0054, -1);
    load_fresh(32'h0000_0154, -1);
    mark_bursts();
    load_fresh(32'h0000_0254, -1);
    check_bursts("clean eviction", 1, 0);
endtask

task automatic lru_order();
    load_fresh(32'h0000_0068, -1);      // A
    load_fresh(32'h0000_0168, -1);      // B
    load_fresh(32'h0000_0068, 1);       // touch A
    mark_bursts();
    load_fresh(32'h0000_0268, -1);      // C takes the way of B
    check_bursts("lru fill", 1, 0);
    load_fresh(32'h0000_0068, 1);
    check_bursts("lru keep", 1, 0);
    load_fresh(32'h0000_0168, -1);
    check_bursts("lru reload", 2, 0);
endtask

// File: verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
    import dcache_cfg_pkg::*, dcache_bus_pkg::*;
();

    logic         clk = 1'b0;
    logic         rstn;
    logic         rvalid, wvalid;
    cpu_req_t     cpu_req;
    logic         rready, wready;
    word_t        rdata;
    logic         d_rvalid, d_rready;
    addr_t        d_raddr;
    mem_rd_beat_t rd_beat;
    logic         d_wvalid, d_wready;
    mem_wr_beat_t wr_beat;
    logic         d_bvalid, d_bready;

    // memory model state
    word_t mem [4096];
    int    rd_cnt = 0;          // beat within the current read burst
    int    wr_cnt = 0;
    int    b_wait = 0;          // cycles left before the write response
    bit    b_pending = 1'b0;
    int    rd_bursts = 0;
    int    wr_bursts = 0;
    int    rd_mark, wr_mark;
    int    errors = 0;
    word_t rd_words[$];         // beats of the latest read burst
    addr_t wr_addr_log[$];
    word_t wr_data_log[$];
    logic  wr_last_log[$];

    always #5 clk = ~clk;

    dcache_top u_dut (
        .clk, .rstn, .rvalid, .wvalid, .cpu_req, .rready, .wready, .rdata,
        .d_rvalid, .d_rready, .d_raddr, .rd_beat,
        .d_wvalid, .d_wready, .wr_beat, .d_bvalid, .d_bready
    );

    // initial memory contents, every address bit takes part
    function automatic word_t init_word(addr_t a);
        return {a[15:0] ^ 16'hc3a5, a[31:16] ^ ~a[15:0]};
    endfunction

    function automatic int mem_index(addr_t a);
        return int'(a[13:2]);
    endfunction

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////
    initial begin
        void'($urandom(32'h6ab9c3a2));   // seeds the ready and response delays
        forever begin
            @(negedge clk);
            if (rstn) begin
                // response ready only while a write-back is under way
                check_value("d_bready outside a write-back", d_bready, d_wvalid || b_pending);
                // read side, a beat goes over at the next edge when both are high
                d_rready      = d_rvalid && ($urandom_range(3) != 0);
                rd_beat.rdata = mem[mem_index(d_raddr + addr_t'(4 * rd_cnt))];
                rd_beat.rlast = (rd_cnt == word_num - 1);
                if (d_rvalid && d_rready) begin
                    if (rd_cnt == 0) rd_words.delete();
                    rd_words.push_back(rd_beat.rdata);
                    rd_cnt = rd_beat.rlast ? 0 : rd_cnt + 1;
                    if (rd_beat.rlast) rd_bursts++;
                end
                d_bvalid = 1'b0;    // taken at the last edge, d_bready was high
                d_wready = d_wvalid && ($urandom_range(3) != 0);
                if (d_wvalid && d_wready) begin
                    mem[mem_index(wr_beat.waddr + addr_t'(4 * wr_cnt))] = wr_beat.wdata;
                    wr_addr_log.push_back(wr_beat.waddr);
                    wr_data_log.push_back(wr_beat.wdata);
                    wr_last_log.push_back(wr_beat.wlast);
                    wr_cnt = wr_beat.wlast ? 0 : wr_cnt + 1;
                    if (wr_beat.wlast) begin
                        wr_bursts++;
                        b_pending = 1'b1;
                        b_wait    = $urandom_range(3);
                    end
                end else if (b_pending && d_bready) begin
                    if (b_wait == 0) begin
                        d_bvalid  = 1'b1;
                        b_pending = 1'b0;
                    end else begin
                        b_wait--;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////
    task automatic fail_and_stop();
        $display("TEST FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        fail_and_stop();
    endtask

    // handshake outputs are all low straight out of reset
    task automatic check_reset_state();
        check_value("rready after reset", rready, 1'b0);
        check_value("wready after reset", wready, 1'b0);
        check_value("d_rvalid after reset", d_rvalid, 1'b0);
        check_value("d_wvalid after reset", d_wvalid, 1'b0);
        check_value("wlast after reset", wr_beat.wlast, 1'b0);
        check_value("d_bready after reset", d_bready, 1'b0);
    endtask

    `include "dcache_tests.svh"

    initial begin
        rstn     = 1'b0;
        rvalid   = 1'b0;
        wvalid   = 1'b0;
        cpu_req  = '0;
        d_rready = 1'b0;
        rd_beat  = '0;
        d_wready = 1'b0;
        d_bvalid = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = init_word(addr_t'(i * 4));
        end
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        check_reset_state();

        load_miss_then_hit();
        store_hit_partial();
        store_miss_allocate();
        dirty_eviction();
        clean_eviction();
        lru_order();

        if (errors == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_and_stop();
        end
    end

endmodule

// File: dcache_top.f
+incdir+verification
hw/dcache_cfg_pkg.sv
hw/dcache_bus_pkg.sv
hw/dcache_arrays.sv
hw/refill_unit.sv
hw/writeback_unit.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the dcache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module dcache_tb -f dcache_top.f \
    -o dcache_sim &&
./obj_dir/dcache_sim | tee /dev/stderr | grep -q "^TEST OK$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
